//--- dma_pkg.sv
package dma_pkg;

    localparam int NUM_STREAMS = 4;
    localparam int STREAM_W    = 2;
    localparam int WORD_BYTES  = 4;

    typedef logic [31:0]         addr_t;
    typedef logic [31:0]         data_t;
    typedef logic [15:0]         count_t;
    typedef logic [1:0]          prio_t;
    typedef logic [STREAM_W-1:0] stream_t;

    // offsets inside the 16-byte block that stream n has at n*16
    localparam addr_t REG_CR   = 32'h00;
    localparam addr_t REG_NDTR = 32'h04;
    localparam addr_t REG_SAR  = 32'h08;
    localparam addr_t REG_DAR  = 32'h0C;

    // shared status registers above the stream blocks
    localparam addr_t REG_ISR  = 32'h40;
    localparam addr_t REG_IFCR = 32'h44;

    // field order follows the CR bit layout from en at bit 0 up to prio at 6..5
    typedef struct packed {
        prio_t prio;
        logic  teie;
        logic  tcie;
        logic  dinc;
        logic  sinc;
        logic  en;
    } stream_cfg_t;

    localparam int CFG_W = $bits(stream_cfg_t);

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        data_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        XS_IDLE,
        XS_ARB,
        XS_READ,
        XS_WRITE
    } xfer_state_t;

endpackage

//--- dma_regs.sv
`timescale 1ns/1ps

module dma_regs (
    input  logic                                            i_hclk,
    input  logic                                            i_rst_n,
    input  dma_pkg::wb_req_t                                i_wbs_req,
    output dma_pkg::wb_rsp_t                                o_wbs_rsp,
    input  dma_pkg::count_t     [dma_pkg::NUM_STREAMS-1:0]  i_remaining,
    input  logic                [dma_pkg::NUM_STREAMS-1:0]  i_done,
    input  logic                                            i_err,
    input  dma_pkg::stream_t                                i_err_sel,
    output dma_pkg::stream_cfg_t [dma_pkg::NUM_STREAMS-1:0] o_cfg,
    output logic                [dma_pkg::NUM_STREAMS-1:0]  o_load,
    output dma_pkg::count_t     [dma_pkg::NUM_STREAMS-1:0]  o_ndtr,
    output dma_pkg::addr_t      [dma_pkg::NUM_STREAMS-1:0]  o_sar,
    output dma_pkg::addr_t      [dma_pkg::NUM_STREAMS-1:0]  o_dar,
    output logic                [dma_pkg::NUM_STREAMS-1:0]  o_irq
);

    logic                              ack_q;
    dma_pkg::data_t                    rdat_q;
    dma_pkg::data_t                    rd_data;
    logic [2*dma_pkg::NUM_STREAMS-1:0] isr;
    logic                              access;
    logic                              wr_en;
    logic                              in_stream;
    dma_pkg::stream_t                  s;
    dma_pkg::addr_t                    off;

    // the ack cycle itself does not start a second access
    assign access    = i_wbs_req.cyc && i_wbs_req.stb && !ack_q;
    assign wr_en     = access && i_wbs_req.we;
    assign in_stream = i_wbs_req.adr < dma_pkg::REG_ISR;
    assign s         = i_wbs_req.adr[dma_pkg::STREAM_W+3:4];
    assign off       = {28'd0, i_wbs_req.adr[3:0]};

    assign o_wbs_rsp = '{ack: ack_q, err: 1'b0, dat: rdat_q};

    always_comb begin
        rd_data = '0;
        if (in_stream) begin
            case (off)
                dma_pkg::REG_CR:   rd_data = dma_pkg::data_t'(o_cfg[s]);
                // live count rather than the programmed one
                dma_pkg::REG_NDTR: rd_data = dma_pkg::data_t'(i_remaining[s]);
                dma_pkg::REG_SAR:  rd_data = o_sar[s];
                dma_pkg::REG_DAR:  rd_data = o_dar[s];
                default:           rd_data = '0;
            endcase
        end else if (i_wbs_req.adr == dma_pkg::REG_ISR) begin
            rd_data = dma_pkg::data_t'(isr);
        end
    end

    always_ff @(posedge i_hclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge i_hclk) begin
        if (access) begin
            rdat_q <= rd_data;
        end
        if (wr_en && in_stream) begin
            case (off)
                dma_pkg::REG_NDTR: o_ndtr[s] <= dma_pkg::count_t'(i_wbs_req.dat);
                dma_pkg::REG_SAR:  o_sar[s]  <= i_wbs_req.dat;
                dma_pkg::REG_DAR:  o_dar[s]  <= i_wbs_req.dat;
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_hclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cfg  <= '0;
            o_load <= '0;
            isr    <= '0;
        end else begin
            o_load <= '0;
            if (wr_en && in_stream && off == dma_pkg::REG_CR) begin
                o_cfg[s]  <= dma_pkg::stream_cfg_t'(i_wbs_req.dat[dma_pkg::CFG_W-1:0]);
                // reload working counters only on a rising enable
                o_load[s] <= i_wbs_req.dat[0] && !o_cfg[s].en;
            end
            if (wr_en && i_wbs_req.adr == dma_pkg::REG_IFCR) begin
                isr <= isr & ~i_wbs_req.dat[2*dma_pkg::NUM_STREAMS-1:0];
            end
            // completion and error win over a software write in the same cycle
            for (int i = 0; i < dma_pkg::NUM_STREAMS; i++) begin
                if (i_done[i]) begin
                    isr[2*i]    <= 1'b1;
                    o_cfg[i].en <= 1'b0;
                end
                if (i_err && i_err_sel == dma_pkg::stream_t'(i)) begin
                    isr[2*i+1]  <= 1'b1;
                    o_cfg[i].en <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < dma_pkg::NUM_STREAMS; i++) begin
            o_irq[i] = (isr[2*i] && o_cfg[i].tcie) || (isr[2*i+1] && o_cfg[i].teie);
        end
    end

endmodule

//--- dma_arbiter.sv
`timescale 1ns/1ps

module dma_arbiter (
    input  logic                                            i_hclk,
    input  logic                                            i_rst_n,
    input  logic                                            i_req,
    input  dma_pkg::stream_cfg_t [dma_pkg::NUM_STREAMS-1:0] i_cfg,
    input  dma_pkg::count_t     [dma_pkg::NUM_STREAMS-1:0]  i_remaining,
    output logic                                            o_valid,
    output dma_pkg::stream_t                                o_sel
);

    logic             found;
    dma_pkg::stream_t best_sel;
    dma_pkg::prio_t   best_prio;

    always_comb begin
        found     = 1'b0;
        best_sel  = '0;
        best_prio = '0;
        for (int i = 0; i < dma_pkg::NUM_STREAMS; i++) begin
            // strict compare keeps the lower index on a tie
            if (i_cfg[i].en && i_remaining[i] != '0 &&
                (!found || i_cfg[i].prio > best_prio)) begin
                found     = 1'b1;
                best_sel  = dma_pkg::stream_t'(i);
                best_prio = i_cfg[i].prio;
            end
        end
    end

    always_ff @(posedge i_hclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_sel   <= '0;
        end else begin
            o_valid <= i_req && found;
            if (i_req && found) begin
                o_sel <= best_sel;
            end
        end
    end

endmodule

//--- dma_stream_counter.sv
`timescale 1ns/1ps

module dma_stream_counter (
    input  logic                                            i_hclk,
    input  logic                                            i_rst_n,
    input  logic                [dma_pkg::NUM_STREAMS-1:0]  i_load,
    input  dma_pkg::count_t     [dma_pkg::NUM_STREAMS-1:0]  i_ndtr,
    input  dma_pkg::addr_t      [dma_pkg::NUM_STREAMS-1:0]  i_sar,
    input  dma_pkg::addr_t      [dma_pkg::NUM_STREAMS-1:0]  i_dar,
    input  dma_pkg::stream_cfg_t [dma_pkg::NUM_STREAMS-1:0] i_cfg,
    input  logic                                            i_step,
    input  dma_pkg::stream_t                                i_step_sel,
    output dma_pkg::count_t     [dma_pkg::NUM_STREAMS-1:0]  o_remaining,
    output dma_pkg::addr_t      [dma_pkg::NUM_STREAMS-1:0]  o_src,
    output dma_pkg::addr_t      [dma_pkg::NUM_STREAMS-1:0]  o_dst,
    output logic                [dma_pkg::NUM_STREAMS-1:0]  o_done
);

    logic [dma_pkg::NUM_STREAMS-1:0] hit;

    always_comb begin
        for (int i = 0; i < dma_pkg::NUM_STREAMS; i++) begin
            hit[i] = i_step && i_step_sel == dma_pkg::stream_t'(i);
        end
    end

    always_ff @(posedge i_hclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_remaining <= '0;
            o_done      <= '0;
        end else begin
            o_done <= '0;
            for (int i = 0; i < dma_pkg::NUM_STREAMS; i++) begin
                if (i_load[i]) begin
                    o_remaining[i] <= i_ndtr[i];
                end else if (hit[i] && o_remaining[i] != '0) begin
                    o_remaining[i] <= o_remaining[i] - 1'b1;
                    o_done[i]      <= o_remaining[i] == dma_pkg::count_t'(1);
                end
            end
        end
    end

    always_ff @(posedge i_hclk) begin
        for (int i = 0; i < dma_pkg::NUM_STREAMS; i++) begin
            if (i_load[i]) begin
                o_src[i] <= i_sar[i];
                o_dst[i] <= i_dar[i];
            end else if (hit[i]) begin
                if (i_cfg[i].sinc) begin
                    o_src[i] <= o_src[i] + dma_pkg::addr_t'(dma_pkg::WORD_BYTES);
                end
                if (i_cfg[i].dinc) begin
                    o_dst[i] <= o_dst[i] + dma_pkg::addr_t'(dma_pkg::WORD_BYTES);
                end
            end
        end
    end

endmodule

//--- dma_xfer_fsm.sv
`timescale 1ns/1ps

module dma_xfer_fsm (
    input  logic                                       i_hclk,
    input  logic                                       i_rst_n,
    input  logic                                       i_grant_valid,
    input  dma_pkg::stream_t                           i_grant_sel,
    input  dma_pkg::addr_t [dma_pkg::NUM_STREAMS-1:0]  i_src,
    input  dma_pkg::addr_t [dma_pkg::NUM_STREAMS-1:0]  i_dst,
    input  dma_pkg::wb_rsp_t                           i_wbm_rsp,
    output logic                                       o_grant_req,
    output dma_pkg::wb_req_t                           o_wbm_req,
    output logic                                       o_step,
    output dma_pkg::stream_t                           o_step_sel,
    output logic                                       o_err,
    output dma_pkg::stream_t                           o_err_sel
);

    dma_pkg::xfer_state_t state;
    dma_pkg::stream_t     sel;

    // wait out the step or error cycle so counts and enables are current
    assign o_grant_req = state == dma_pkg::XS_IDLE && !o_step && !o_err;
    assign o_step_sel  = sel;
    assign o_err_sel   = sel;

    always_ff @(posedge i_hclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= dma_pkg::XS_IDLE;
            sel       <= '0;
            o_wbm_req <= '0;
            o_step    <= 1'b0;
            o_err     <= 1'b0;
        end else begin
            o_step <= 1'b0;
            o_err  <= 1'b0;
            case (state)
                dma_pkg::XS_IDLE: begin
                    if (o_grant_req) begin
                        state <= dma_pkg::XS_ARB;
                    end
                end
                dma_pkg::XS_ARB: begin
                    if (i_grant_valid) begin
                        sel           <= i_grant_sel;
                        o_wbm_req.cyc <= 1'b1;
                        o_wbm_req.stb <= 1'b1;
                        o_wbm_req.we  <= 1'b0;
                        o_wbm_req.adr <= i_src[i_grant_sel];
                        state         <= dma_pkg::XS_READ;
                    end else begin
                        state <= dma_pkg::XS_IDLE;
                    end
                end
                dma_pkg::XS_READ: begin
                    if (i_wbm_rsp.err) begin
                        o_wbm_req.cyc <= 1'b0;
                        o_wbm_req.stb <= 1'b0;
                        o_err         <= 1'b1;
                        state         <= dma_pkg::XS_IDLE;
                    end else if (i_wbm_rsp.ack) begin
                        // read word stays in the data field for the write
                        o_wbm_req.cyc <= 1'b0;
                        o_wbm_req.stb <= 1'b0;
                        o_wbm_req.dat <= i_wbm_rsp.dat;
                        state         <= dma_pkg::XS_WRITE;
                    end
                end
                dma_pkg::XS_WRITE: begin
                    // first cycle here is the bus idle cycle between phases
                    if (!o_wbm_req.cyc) begin
                        o_wbm_req.cyc <= 1'b1;
                        o_wbm_req.stb <= 1'b1;
                        o_wbm_req.we  <= 1'b1;
                        o_wbm_req.adr <= i_dst[sel];
                    end else if (i_wbm_rsp.err) begin
                        o_wbm_req.cyc <= 1'b0;
                        o_wbm_req.stb <= 1'b0;
                        o_err         <= 1'b1;
                        state         <= dma_pkg::XS_IDLE;
                    end else if (i_wbm_rsp.ack) begin
                        o_wbm_req.cyc <= 1'b0;
                        o_wbm_req.stb <= 1'b0;
                        o_step        <= 1'b1;
                        state         <= dma_pkg::XS_IDLE;
                    end
                end
                default: state <= dma_pkg::XS_IDLE;
            endcase
        end
    end

endmodule

//--- dma_wb_top.sv
`timescale 1ns/1ps

module dma_wb_top (
    input  logic                            i_hclk,
    input  logic                            i_rst_n,
    input  dma_pkg::wb_req_t                i_wbs_req,
    output dma_pkg::wb_rsp_t                o_wbs_rsp,
    output dma_pkg::wb_req_t                o_wbm_req,
    input  dma_pkg::wb_rsp_t                i_wbm_rsp,
    output logic [dma_pkg::NUM_STREAMS-1:0] o_irq
);

    dma_pkg::stream_cfg_t [dma_pkg::NUM_STREAMS-1:0] cfg;
    logic                 [dma_pkg::NUM_STREAMS-1:0] load;
    logic                 [dma_pkg::NUM_STREAMS-1:0] done;
    dma_pkg::count_t      [dma_pkg::NUM_STREAMS-1:0] ndtr;
    dma_pkg::count_t      [dma_pkg::NUM_STREAMS-1:0] remaining;
    dma_pkg::addr_t       [dma_pkg::NUM_STREAMS-1:0] sar;
    dma_pkg::addr_t       [dma_pkg::NUM_STREAMS-1:0] dar;
    dma_pkg::addr_t       [dma_pkg::NUM_STREAMS-1:0] src;
    dma_pkg::addr_t       [dma_pkg::NUM_STREAMS-1:0] dst;
    logic                                            grant_req;
    logic                                            grant_valid;
    dma_pkg::stream_t                                grant_sel;
    logic                                            step;
    dma_pkg::stream_t                                step_sel;
    logic                                            err;
    dma_pkg::stream_t                                err_sel;

    dma_regs u_regs (
        .i_hclk      (i_hclk),
        .i_rst_n     (i_rst_n),
        .i_wbs_req   (i_wbs_req),
        .o_wbs_rsp   (o_wbs_rsp),
        .i_remaining (remaining),
        .i_done      (done),
        .i_err       (err),
        .i_err_sel   (err_sel),
        .o_cfg       (cfg),
        .o_load      (load),
        .o_ndtr      (ndtr),
        .o_sar       (sar),
        .o_dar       (dar),
        .o_irq       (o_irq)
    );

    dma_arbiter u_arbiter (
        .i_hclk      (i_hclk),
        .i_rst_n     (i_rst_n),
        .i_req       (grant_req),
        .i_cfg       (cfg),
        .i_remaining (remaining),
        .o_valid     (grant_valid),
        .o_sel       (grant_sel)
    );

    dma_stream_counter u_counter (
        .i_hclk      (i_hclk),
        .i_rst_n     (i_rst_n),
        .i_load      (load),
        .i_ndtr      (ndtr),
        .i_sar       (sar),
        .i_dar       (dar),
        .i_cfg       (cfg),
        .i_step      (step),
        .i_step_sel  (step_sel),
        .o_remaining (remaining),
        .o_src       (src),
        .o_dst       (dst),
        .o_done      (done)
    );

    dma_xfer_fsm u_xfer_fsm (
        .i_hclk        (i_hclk),
        .i_rst_n       (i_rst_n),
        .i_grant_valid (grant_valid),
        .i_grant_sel   (grant_sel),
        .i_src         (src),
        .i_dst         (dst),
        .i_wbm_rsp     (i_wbm_rsp),
        .o_grant_req   (grant_req),
        .o_wbm_req     (o_wbm_req),
        .o_step        (step),
        .o_step_sel    (step_sel),
        .o_err         (err),
        .o_err_sel     (err_sel)
    );

endmodule

//--- dma_wb_sva.sv
`timescale 1ns/1ps

module dma_wb_sva (
    input logic             i_hclk,
    input logic             i_rst_n,
    input dma_pkg::wb_req_t i_wbs_req,
    input dma_pkg::wb_rsp_t i_wbs_rsp,
    input dma_pkg::wb_req_t i_wbm_req,
    input dma_pkg::wb_rsp_t i_wbm_rsp
);

    // master side request held until the memory answers
    wbm_req_held: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
        (i_wbm_req.cyc && i_wbm_req.stb && !i_wbm_rsp.ack && !i_wbm_rsp.err)
        |=> (i_wbm_req.cyc && i_wbm_req.stb
             && $stable({i_wbm_req.we, i_wbm_req.adr, i_wbm_req.dat})))
        else $error("master request changed before ack or err");

    wbm_rsp_framed: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
        (i_wbm_rsp.ack || i_wbm_rsp.err) |-> (i_wbm_req.cyc && i_wbm_req.stb))
        else $error("master port saw ack or err outside a cycle");

    // register slave side
    wbs_ack_framed: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
        i_wbs_rsp.ack |-> (i_wbs_req.cyc && i_wbs_req.stb))
        else $error("register slave acked outside a cycle");

endmodule

bind dma_wb_top dma_wb_sva dma_wb_sva_inst (
    .i_hclk    (i_hclk),
    .i_rst_n   (i_rst_n),
    .i_wbs_req (i_wbs_req),
    .i_wbs_rsp (o_wbs_rsp),
    .i_wbm_req (o_wbm_req),
    .i_wbm_rsp (i_wbm_rsp)
);

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // reset released just after the fifth rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- dma_wb_tb.sv
`timescale 1ns/1ps

module dma_wb_tb;

    localparam int MEM_WORDS  = 1024;
    // about 40 words at up to 14 cycles each plus register polling fit with wide margin
    localparam int MAX_CYCLES = 20000;

    logic                            clk;
    logic                            rst_n;
    dma_pkg::wb_req_t                wbs_req = '0;
    dma_pkg::wb_rsp_t                wbs_rsp;
    dma_pkg::wb_req_t                wbm_req;
    dma_pkg::wb_rsp_t                wbm_rsp = '0;
    logic [dma_pkg::NUM_STREAMS-1:0] irq;

    dma_pkg::data_t mem     [MEM_WORDS];
    dma_pkg::data_t exp_mem [MEM_WORDS];
    integer         seed      = 77;
    int             errors    = 0;
    int             checks    = 0;
    int             cycles    = 0;
    logic           check_req = 1'b0;
    logic           busy      = 1'b0;
    int             wait_cnt  = 0;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    dma_wb_top dma_wb_top_inst (
        .i_hclk    (clk),
        .i_rst_n   (rst_n),
        .i_wbs_req (wbs_req),
        .o_wbs_rsp (wbs_rsp),
        .o_wbm_req (wbm_req),
        .i_wbm_rsp (wbm_rsp),
        .o_irq     (irq)
    );

    function automatic dma_pkg::data_t fill_word(input int idx);
        return dma_pkg::data_t'(idx) * 32'h9E37_79B1 + 32'h0BAD_F00D;
    endfunction

    function automatic int word_index(input dma_pkg::addr_t a);
        return int'(a[11:2]);
    endfunction

    function automatic dma_pkg::addr_t reg_addr(input int s, input dma_pkg::addr_t off);
        return dma_pkg::addr_t'(s * 16) + off;
    endfunction

    function automatic dma_pkg::data_t cr_value(input logic en, input logic sinc,
            input logic dinc, input logic tcie, input logic teie, input dma_pkg::prio_t prio);
        return {25'd0, prio, teie, tcie, dinc, sinc, en};
    endfunction

    // expected memory built word by word in copy order
    function automatic void copy_expected(input int src_w, input int dst_w, input int n,
                                          input logic sinc, input logic dinc);
        int s;
        int d;
        s = src_w;
        d = dst_w;
        for (int k = 0; k < n; k++) begin
            exp_mem[d] = exp_mem[s];
            s = sinc ? s + 1 : s;
            d = dinc ? d + 1 : d;
        end
    endfunction

    task automatic check_value(input string what, input dma_pkg::data_t got,
                               input dma_pkg::data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic bus_access(input logic we, input dma_pkg::addr_t adr,
                              input dma_pkg::data_t wdat, output dma_pkg::data_t rdat);
        @(posedge clk);
        #1;
        wbs_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge clk);
            #1;
        end while (!wbs_rsp.ack);
        rdat = wbs_rsp.dat;
        check_value("register slave err", dma_pkg::data_t'(wbs_rsp.err), '0);
        // bus goes idle after the edge that takes the ack
        @(posedge clk);
        #1;
        wbs_req = '0;
    endtask

    task automatic write_reg(input dma_pkg::addr_t adr, input dma_pkg::data_t dat);
        dma_pkg::data_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input dma_pkg::addr_t adr, output dma_pkg::data_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic start_stream(input int s, input dma_pkg::addr_t src,
                                input dma_pkg::addr_t dst, input int n, input dma_pkg::data_t cr);
        write_reg(reg_addr(s, dma_pkg::REG_NDTR), dma_pkg::data_t'(n));
        write_reg(reg_addr(s, dma_pkg::REG_SAR), src);
        write_reg(reg_addr(s, dma_pkg::REG_DAR), dst);
        write_reg(reg_addr(s, dma_pkg::REG_CR), cr);
    endtask

    task automatic wait_flags(input dma_pkg::data_t mask, output dma_pkg::data_t isr);
        do begin
            read_reg(dma_pkg::REG_ISR, isr);
        end while ((isr & mask) != mask);
    endtask

    task automatic compare_memory();
        check_req = 1'b1;
        wait (!check_req);
    endtask

    // memory slave with 0 to 3 wait states and err at 0x8000 and up
    always @(posedge clk) begin
        #1;
        if (wbm_rsp.ack || wbm_rsp.err) begin
            wbm_rsp.ack = 1'b0;
            wbm_rsp.err = 1'b0;
            busy        = 1'b0;
        end else if (wbm_req.cyc && wbm_req.stb) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = $unsigned($random(seed)) % 4;
            end
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else if (wbm_req.adr >= 32'h8000) begin
                wbm_rsp.err = 1'b1;
            end else begin
                if (wbm_req.we) begin
                    mem[word_index(wbm_req.adr)] = wbm_req.dat;
                end else begin
                    wbm_rsp.dat = mem[word_index(wbm_req.adr)];
                end
                wbm_rsp.ack = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (check_req) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                checks++;
                assert (mem[i] === exp_mem[i]) else begin
                    errors++;
                    $display("FAILED at %0t ns: mem[%0d] is 0x%08h, expected 0x%08h",
                             $time, i, mem[i], exp_mem[i]);
                end
            end
            check_req = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles, %0d errors", cycles, errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        dma_pkg::data_t v;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = fill_word(i);
            exp_mem[i] = mem[i];
        end
        wait (rst_n === 1'b1);

        read_reg(dma_pkg::REG_ISR, v);
        check_value("ISR after reset", v, '0);
        check_value("irq after reset", dma_pkg::data_t'(irq), '0);

        // NDTR reads the live count and stays 0 until enable rises
        for (int s = 0; s < dma_pkg::NUM_STREAMS; s++) begin
            write_reg(reg_addr(s, dma_pkg::REG_CR),
                      cr_value(1'b0, s[0], !s[0], 1'b1, s[1], s[1:0]));
            write_reg(reg_addr(s, dma_pkg::REG_NDTR), dma_pkg::data_t'(16'h0100 + s));
            write_reg(reg_addr(s, dma_pkg::REG_SAR), 32'h1000_0000 + s * 32'h0001_0104);
            write_reg(reg_addr(s, dma_pkg::REG_DAR), 32'h2000_0040 + s * 32'h0010_0010);
            read_reg(reg_addr(s, dma_pkg::REG_CR), v);
            check_value("CR readback", v, cr_value(1'b0, s[0], !s[0], 1'b1, s[1], s[1:0]));
            read_reg(reg_addr(s, dma_pkg::REG_NDTR), v);
            check_value("NDTR readback", v, '0);
            read_reg(reg_addr(s, dma_pkg::REG_SAR), v);
            check_value("SAR readback", v, 32'h1000_0000 + s * 32'h0001_0104);
            read_reg(reg_addr(s, dma_pkg::REG_DAR), v);
            check_value("DAR readback", v, 32'h2000_0040 + s * 32'h0010_0010);
        end

        // single stream with both increments
        write_reg(dma_pkg::REG_IFCR, 32'hFF);
        start_stream(0, 32'h000, 32'h400, 12, cr_value(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd0));
        wait_flags(32'h01, v);
        copy_expected(0, 256, 12, 1'b1, 1'b1);
        compare_memory();
        check_value("ISR after stream 0", v, 32'h01);
        check_value("irq after stream 0", dma_pkg::data_t'(irq), 32'h1);
        read_reg(reg_addr(0, dma_pkg::REG_NDTR), v);
        check_value("NDTR after stream 0", v, '0);

        // fixed source, then fixed destination
        write_reg(dma_pkg::REG_IFCR, 32'hFF);
        start_stream(1, 32'h100, 32'h600, 6, cr_value(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd1));
        wait_flags(32'h04, v);
        copy_expected(64, 384, 6, 1'b0, 1'b1);
        start_stream(2, 32'h180, 32'h700, 5, cr_value(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd2));
        wait_flags(32'h10, v);
        copy_expected(96, 448, 5, 1'b1, 1'b0);
        compare_memory();
        check_value("fixed destination word", mem[448], fill_word(100));

        // low priority stream 0 first, high priority stream 3 second
        write_reg(dma_pkg::REG_IFCR, 32'hFF);
        start_stream(0, 32'h200, 32'h800, 8, cr_value(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd0));
        start_stream(3, 32'h280, 32'h900, 8, cr_value(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd3));
        wait_flags(32'h40, v);
        check_value("stream 0 flag when stream 3 completes", v & 32'h01, '0);
        wait_flags(32'h01, v);
        copy_expected(128, 512, 8, 1'b1, 1'b1);
        copy_expected(160, 576, 8, 1'b1, 1'b1);
        compare_memory();

        // bus error on the source read while earlier flags stay set
        start_stream(2, 32'h8000, 32'hA00, 4, cr_value(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 2'd1));
        wait_flags(32'h20, v);
        check_value("ISR after error", v, 32'h61);
        read_reg(reg_addr(2, dma_pkg::REG_CR), v);
        check_value("CR after error", v, cr_value(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 2'd1));
        check_value("irq after error", dma_pkg::data_t'(irq), 32'hD);
        compare_memory();

        write_reg(dma_pkg::REG_IFCR, 32'h20);
        read_reg(dma_pkg::REG_ISR, v);
        check_value("ISR after clearing error", v, 32'h41);
        check_value("irq after clearing error", dma_pkg::data_t'(irq), 32'h9);
        write_reg(dma_pkg::REG_IFCR, 32'h41);
        read_reg(dma_pkg::REG_ISR, v);
        check_value("ISR after clearing all", v, '0);
        check_value("irq after clearing all", dma_pkg::data_t'(irq), '0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- dma_wb.f
dma_pkg.sv
dma_regs.sv
dma_arbiter.sv
dma_stream_counter.sv
dma_xfer_fsm.sv
dma_wb_top.sv
dma_wb_sva.sv
tb_clkgen.sv
dma_wb_tb.sv

//--- Makefile
TOP := dma_wb_tb

.PHONY: all sim lint clean

all: sim

obj_dir/V$(TOP): dma_wb.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f dma_wb.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -Wno-fatal --top-module $(TOP) -f dma_wb.f

clean:
	rm -rf obj_dir sim.log
